// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module gpio_tb -f src.f -o gpio_tb

run: compile
	@out=$$(./obj_dir/gpio_tb 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

// ==== sim/gpio_properties.sv ====
module gpio_properties #(
   parameter int io_num = 32
) (
   input logic                   PCLK,
   input logic                   aresetn,
   input gpio_cfg_pkg::pin_cfg_t cfg_i [io_num-1:0],
   input logic                   pready_i,
   input logic                   pslverr_i,
   input logic [io_num-1:0]      int_i,
   input logic                   int_or_i,
   input logic [io_num-1:0]      gpio_oe_i
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [io_num-1:0] out_en;

   always_comb
   begin
      for (int i = 0; i < io_num; i++)
         out_en[i] = cfg_i[i].out_en;
   end

   // ------------------------------------------------------------
   // bus ties and pin level checks
   // ------------------------------------------------------------
   apb_tie_a: assert property (@(posedge PCLK) disable iff (!aresetn)
      pready_i && !pslverr_i)
      else $error("PREADY or PSLVERR left its fixed level");

   int_or_a: assert property (@(posedge PCLK) disable iff (!aresetn)
      int_or_i == |int_i)
      else $error("INT_OR does not match the OR of INT");

   // output enable only where the output register drives the pin
   oe_gate_a: assert property (@(posedge PCLK) disable iff (!aresetn)
      (gpio_oe_i & ~out_en) == '0)
      else $error("GPIO_OE set on a pin with output drive disabled");

endmodule

// ==== sim/gpio_tb.sv ====
module gpio_tb;
   timeunit 1ns;
   timeprecision 100ps;

   // pin count of the DUT
   localparam int io_num = 8;

   logic                               PCLK;
   logic                               aresetn;
   logic                               psel;
   logic                               penable;
   logic                               pwrite;
   logic [gpio_regmap_pkg::ADDR_W-1:0] paddr;
   logic [gpio_regmap_pkg::DATA_W-1:0] pwdata;
   logic [gpio_regmap_pkg::DATA_W-1:0] prdata;
   logic                               pready;
   logic                               pslverr;
   logic [io_num-1:0]                  int_vec;
   logic                               int_or;
   logic [io_num-1:0]                  gpio_in;
   logic [io_num-1:0]                  gpio_out;
   logic [io_num-1:0]                  gpio_oe;

   gpio_cfg_pkg::pin_cfg_t cfg_model [io_num];
   logic [31:0]            lcg_state = 32'd71036;

   gpio_top #(
      .io_num (io_num),
      .io_val (8'hA5)
   ) gpio_top_inst (
      .PCLK    (PCLK),
      .aresetn (aresetn),
      .PSEL    (psel),
      .PENABLE (penable),
      .PWRITE  (pwrite),
      .PADDR   (paddr),
      .PWDATA  (pwdata),
      .PRDATA  (prdata),
      .PREADY  (pready),
      .PSLVERR (pslverr),
      .INT     (int_vec),
      .INT_OR  (int_or),
      .GPIO_IN (gpio_in),
      .GPIO_OUT(gpio_out),
      .GPIO_OE (gpio_oe)
   );

   bind gpio_top gpio_properties #(
      .io_num (io_num)
   ) props_inst (
      .PCLK      (PCLK),
      .aresetn   (aresetn),
      .cfg_i     (cfg),
      .pready_i  (PREADY),
      .pslverr_i (PSLVERR),
      .int_i     (INT),
      .int_or_i  (INT_OR),
      .gpio_oe_i (GPIO_OE)
   );

   initial
   begin
      PCLK = 1'b0;
      forever #2 PCLK = ~PCLK;
   end

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   function automatic logic [7:0] rand_byte();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      // low bits of this generator repeat quickly
      return lcg_state[23:16];
   endfunction

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_word(input logic [gpio_regmap_pkg::DATA_W-1:0] got,
                             input logic [gpio_regmap_pkg::DATA_W-1:0] exp,
                             input string what);
      if (got !== exp)
         stop_with_failure($sformatf("Error at %0d ns: %s is 0x%08h, expected 0x%08h",
                                     $time, what, got, exp));
   endtask

   task automatic check_cfg(input gpio_cfg_pkg::pin_cfg_t got,
                            input gpio_cfg_pkg::pin_cfg_t exp,
                            input string what);
      if (got !== exp)
         stop_with_failure($sformatf("Error at %0d ns: %s is 0x%02h, expected 0x%02h",
                                     $time, what, got, exp));
   endtask

   // sampled on the falling edge away from the driving edge
   task automatic wait_ready();
      int cycles;
      cycles = 0;
      @(negedge PCLK);
      while (pready !== 1'b1)
      begin
         cycles++;
         if (cycles > 16)
            stop_with_failure("timed out waiting for PREADY during an APB access");
         @(negedge PCLK);
      end
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge PCLK);
      psel   <= 1'b1;
      pwrite <= 1'b1;
      paddr  <= addr;
      pwdata <= data;
      @(posedge PCLK);
      penable <= 1'b1;
      wait_ready();
      @(posedge PCLK);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      @(posedge PCLK);
      psel   <= 1'b1;
      pwrite <= 1'b0;
      paddr  <= addr;
      @(posedge PCLK);
      penable <= 1'b1;
      wait_ready();
      data = prdata;
      @(posedge PCLK);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic write_cfg(input int pin, input gpio_cfg_pkg::pin_cfg_t cfg);
      gpio_cfg_pkg::wdata_u w;
      // pad lane carries junk that the DUT must ignore
      w.mask    = {rand_byte(), rand_byte(), rand_byte(), 8'h00};
      w.cfg.cfg = cfg;
      cfg_model[pin] = cfg;
      apb_write(8'(pin * 4), w.mask);
   endtask

   task automatic clear_cfgs();
      for (int i = 0; i < io_num; i++)
         write_cfg(i, '0);
   endtask

   function automatic gpio_cfg_pkg::pin_cfg_t irq_cfg(input logic [2:0] kind,
                                                      input logic en);
      gpio_cfg_pkg::pin_cfg_t c;
      c          = '0;
      c.int_type = gpio_cfg_pkg::int_type_e'(kind);
      c.int_en   = en;
      c.in_en    = 1'b1;
      return c;
   endfunction

   task automatic enable_masks(output logic [7:0] out_m, output logic [7:0] oe_m,
                               output logic [7:0] in_m);
      for (int i = 0; i < io_num; i++)
      begin
         out_m[i] = cfg_model[i].out_en;
         oe_m[i]  = cfg_model[i].oe_en;
         in_m[i]  = cfg_model[i].in_en;
      end
   endtask

   task automatic set_input(input logic [7:0] value);
      @(posedge PCLK);
      gpio_in <= value;
   endtask

   task automatic wait_int(input int pin, input logic value);
      int cycles;
      cycles = 0;
      @(negedge PCLK);
      while (int_vec[pin] !== value)
      begin
         cycles++;
         if (cycles > 12)
            stop_with_failure($sformatf("timed out waiting for INT[%0d] to become %0b",
                                        pin, value));
         @(negedge PCLK);
      end
   endtask

   task automatic watch_quiet(input logic [7:0] mask, input int cycles);
      for (int i = 0; i < cycles; i++)
      begin
         @(negedge PCLK);
         check_word(32'(int_vec & mask), 32'h0, "INT on a disabled pin");
      end
   endtask

   // ------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------
   task automatic test_reset();
      logic [31:0] data;
      for (int i = 0; i < io_num; i++)
      begin
         apb_read(8'(i * 4), data);
         check_cfg(data[7:0], '0, $sformatf("config of pin %0d after reset", i));
      end
      apb_read(gpio_regmap_pkg::INTR_ADDR, data);
      check_word(data, 32'h0, "interrupt status after reset");
      apb_read(gpio_regmap_pkg::GPOUT_ADDR, data);
      check_word(data, 32'hA5, "GPOUT after reset");
      @(negedge PCLK);
      check_word(32'(gpio_oe), 32'h0, "GPIO_OE after reset");
      check_word(32'(gpio_out), 32'h0, "GPIO_OUT after reset");
      check_word(32'(int_vec), 32'h0, "INT after reset");
   endtask

   task automatic test_cfg_readback();
      logic [31:0] data;
      for (int i = 0; i < io_num; i++)
         write_cfg(i, gpio_cfg_pkg::pin_cfg_t'(rand_byte()));
      // write to a pin that does not exist
      apb_write(8'h20, 32'h0000_00FF);
      for (int i = 0; i < io_num; i++)
      begin
         apb_read(8'(i * 4), data);
         check_cfg(data[7:0], cfg_model[i], $sformatf("config of pin %0d", i));
         check_word(data & 32'hFFFF_FF00, 32'h0, "upper config bits");
      end
      apb_read(8'h20, data);
      check_word(data, 32'h0, "config word beyond the last pin");
   endtask

   task automatic test_output();
      logic [7:0]  gpout;
      logic [7:0]  out_m;
      logic [7:0]  oe_m;
      logic [7:0]  in_m;
      logic [31:0] data;
      for (int round = 0; round < 3; round++)
      begin
         for (int i = 0; i < io_num; i++)
            write_cfg(i, gpio_cfg_pkg::pin_cfg_t'(rand_byte()));
         gpout = rand_byte();
         apb_write(gpio_regmap_pkg::GPOUT_ADDR, 32'(gpout));
         @(negedge PCLK);
         enable_masks(out_m, oe_m, in_m);
         check_word(32'(gpio_out), 32'(gpout & out_m), "GPIO_OUT");
         check_word(32'(gpio_oe), 32'(oe_m & out_m), "GPIO_OE");
         apb_read(gpio_regmap_pkg::GPOUT_ADDR, data);
         check_word(data, 32'(gpout), "GPOUT readback");
      end
   endtask

   task automatic test_input();
      logic [7:0]  value;
      logic [7:0]  out_m;
      logic [7:0]  oe_m;
      logic [7:0]  in_m;
      logic [31:0] data;
      enable_masks(out_m, oe_m, in_m);
      for (int round = 0; round < 4; round++)
      begin
         value = rand_byte();
         set_input(value);
         // synchroniser plus delay stage
         repeat (3) @(posedge PCLK);
         apb_read(gpio_regmap_pkg::GPIN_ADDR, data);
         check_word(data, 32'(value & in_m), "GPIN");
      end
   endtask

   task automatic test_edge_irq();
      logic [31:0] data;
      clear_cfgs();
      set_input(8'h00);
      repeat (4) @(posedge PCLK);
      write_cfg(0, irq_cfg(gpio_cfg_pkg::INT_RISE, 1'b1));
      write_cfg(1, irq_cfg(gpio_cfg_pkg::INT_FALL, 1'b1));
      write_cfg(2, irq_cfg(gpio_cfg_pkg::INT_BOTH, 1'b1));
      set_input(8'h03);
      wait_int(0, 1'b1);
      check_word(32'(int_vec), 32'h01, "INT after rising inputs");
      check_word(32'(int_or), 32'h1, "INT_OR after rising inputs");
      // pins 0 and 1 fall while the rise latch holds
      set_input(8'h00);
      wait_int(1, 1'b1);
      check_word(32'(int_vec), 32'h03, "INT after falling inputs");
      set_input(8'h04);
      wait_int(2, 1'b1);
      check_word(32'(int_vec), 32'h07, "INT after both-edge rise");
      apb_write(gpio_regmap_pkg::INTR_ADDR, 32'h01);
      @(negedge PCLK);
      check_word(32'(int_vec), 32'h06, "INT after clearing pin 0");
      apb_read(gpio_regmap_pkg::INTR_ADDR, data);
      check_word(data, 32'h06, "interrupt status");
      apb_write(gpio_regmap_pkg::INTR_ADDR, 32'h06);
      @(negedge PCLK);
      check_word(32'(int_vec), 32'h00, "INT after clearing pins 1 and 2");
      set_input(8'h00);
      wait_int(2, 1'b1);
      check_word(32'(int_vec), 32'h04, "INT after both-edge fall");
      apb_write(gpio_regmap_pkg::INTR_ADDR, 32'hFF);
      @(negedge PCLK);
      check_word(32'(int_or), 32'h0, "INT_OR after clearing all");
   endtask

   task automatic test_level_irq();
      clear_cfgs();
      set_input(8'h00);
      repeat (4) @(posedge PCLK);
      write_cfg(3, irq_cfg(gpio_cfg_pkg::INT_LEVEL_HIGH, 1'b1));
      write_cfg(4, irq_cfg(gpio_cfg_pkg::INT_LEVEL_LOW, 1'b1));
      write_cfg(5, irq_cfg(3'd7, 1'b1));
      write_cfg(6, irq_cfg(gpio_cfg_pkg::INT_RISE, 1'b0));
      wait_int(4, 1'b1);
      check_word(32'(int_vec), 32'h10, "INT with all inputs low");
      set_input(8'h78);
      wait_int(3, 1'b1);
      wait_int(4, 1'b0);
      watch_quiet(8'h60, 6);
      check_word(32'(int_vec), 32'h08, "INT with inputs high");
      set_input(8'h00);
      wait_int(3, 1'b0);
      wait_int(4, 1'b1);
      watch_quiet(8'h60, 6);
      check_word(32'(int_vec), 32'h10, "INT with inputs low again");
   endtask

   initial
   begin
      aresetn = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      gpio_in = '0;
      repeat (8) @(posedge PCLK);
      aresetn <= 1'b1;
      test_reset();
      test_cfg_readback();
      test_output();
      test_input();
      test_edge_irq();
      test_level_irq();
      $display("all tests passed");
      $finish;
   end

endmodule

// ==== src.f ====
verilog/gpio_cfg_pkg.sv
verilog/gpio_regmap_pkg.sv
verilog/gpio_in_sync.sv
verilog/gpio_irq.sv
verilog/gpio_apb_regs.sv
verilog/gpio_top.sv
sim/gpio_properties.sv
sim/gpio_tb.sv

// ==== verilog/gpio_apb_regs.sv ====
module gpio_apb_regs #(
   parameter int                io_num = 32,
   parameter logic [io_num-1:0] io_val = '0
) (
   input  logic                               PCLK,
   input  logic                               aresetn,
   input  logic                               psel_i,
   input  logic                               penable_i,
   input  logic                               pwrite_i,
   input  logic [gpio_regmap_pkg::ADDR_W-1:0] paddr_i,
   input  gpio_cfg_pkg::wdata_u               pwdata_i,
   output logic [gpio_regmap_pkg::DATA_W-1:0] prdata_o,
   input  logic [io_num-1:0]                  level_i,
   input  logic [io_num-1:0]                  intr_stat_i,
   output gpio_cfg_pkg::pin_cfg_t             cfg_o [io_num-1:0],
   output logic                               irq_clr_o,
   output logic [io_num-1:0]                  irq_clr_mask_o,
   output logic [io_num-1:0]                  gpio_out_o,
   output logic [io_num-1:0]                  gpio_oe_o
);

   logic                               wr_en;
   logic                               cfg_hit;
   logic [gpio_regmap_pkg::ADDR_W-3:0] pin_idx;
   gpio_cfg_pkg::pin_cfg_t             cfg_q [io_num-1:0];
   gpio_cfg_pkg::pin_cfg_t             cfg_rd;
   logic [io_num-1:0]                  gpout_q;
   logic [io_num-1:0]                  gpin;
   logic [io_num-1:0]                  out_en;
   logic [io_num-1:0]                  oe_en;
   logic [io_num-1:0]                  in_en;

   // ------------------------------------------------------------
   // write decode
   // ------------------------------------------------------------
   assign wr_en   = psel_i & penable_i & pwrite_i;
   assign cfg_hit = paddr_i < gpio_regmap_pkg::CFG_LIMIT;
   // word address selects the pin
   assign pin_idx = paddr_i[gpio_regmap_pkg::ADDR_W-1:2];

   assign irq_clr_o      = wr_en && (paddr_i == gpio_regmap_pkg::INTR_ADDR);
   assign irq_clr_mask_o = pwdata_i.mask[io_num-1:0];

   // config bytes, one per pin
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         for (int i = 0; i < io_num; i++)
            cfg_q[i] <= '0;
      end
      else if (wr_en && cfg_hit)
      begin
         for (int i = 0; i < io_num; i++)
            if (pin_idx == i)
               cfg_q[i] <= pwdata_i.cfg.cfg;
      end
   end

   // output register
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         gpout_q <= io_val;
      else if (wr_en && (paddr_i == gpio_regmap_pkg::GPOUT_ADDR))
         gpout_q <= pwdata_i.mask[io_num-1:0];
   end

   assign cfg_o = cfg_q;

   // ------------------------------------------------------------
   // pin drive and input gating
   // ------------------------------------------------------------
   always_comb
   begin
      for (int i = 0; i < io_num; i++)
      begin
         out_en[i] = cfg_q[i].out_en;
         oe_en[i]  = cfg_q[i].oe_en;
         in_en[i]  = cfg_q[i].in_en;
      end
   end

   assign gpio_out_o = gpout_q & out_en;
   // drive only where the output register is enabled too
   assign gpio_oe_o  = oe_en & out_en;
   assign gpin       = level_i & in_en;

   // ------------------------------------------------------------
   // read mux
   // ------------------------------------------------------------
   // pins at or beyond io_num read as zero
   always_comb
   begin
      cfg_rd = '0;
      for (int i = 0; i < io_num; i++)
         if (pin_idx == i)
            cfg_rd = cfg_q[i];
   end

   always_comb
   begin
      prdata_o = '0;
      if (cfg_hit)
         prdata_o[7:0] = cfg_rd;
      else if (paddr_i == gpio_regmap_pkg::INTR_ADDR)
         prdata_o[io_num-1:0] = intr_stat_i;
      else if (paddr_i == gpio_regmap_pkg::GPIN_ADDR)
         prdata_o[io_num-1:0] = gpin;
      else if (paddr_i == gpio_regmap_pkg::GPOUT_ADDR)
         prdata_o[io_num-1:0] = gpout_q;
   end

endmodule

// ==== verilog/gpio_cfg_pkg.sv ====
package gpio_cfg_pkg;

   // ------------------------------------------------------------
   // interrupt type, bits 7:5 of a pin configuration byte
   // ------------------------------------------------------------
   // codes 5 to 7 are left unnamed and disable the pin interrupt
   typedef enum logic [2:0] {
      INT_LEVEL_HIGH = 3'd0,
      INT_LEVEL_LOW  = 3'd1,
      INT_RISE       = 3'd2,
      INT_FALL       = 3'd3,
      INT_BOTH       = 3'd4
   } int_type_e;

   // per-pin configuration byte, msb first
   typedef struct packed {
      int_type_e int_type;
      logic      unused;
      logic      int_en;
      logic      oe_en;
      logic      in_en;
      logic      out_en;
   } pin_cfg_t;

   // config byte in the low lane of a write word
   typedef struct packed {
      logic [23:0] pad;
      pin_cfg_t    cfg;
   } cfg_word_t;

   // one apb write word, seen as a bit mask or as a config word
   typedef union packed {
      logic [31:0] mask;
      cfg_word_t   cfg;
   } wdata_u;

endpackage

// ==== verilog/gpio_in_sync.sv ====
module gpio_in_sync #(
   parameter int io_num = 32
) (
   input  logic              PCLK,
   input  logic              aresetn,
   input  logic [io_num-1:0] gpio_i,
   output logic [io_num-1:0] level_o,
   output logic [io_num-1:0] rise_o,
   output logic [io_num-1:0] fall_o
);

   logic [io_num-1:0] sync1;
   logic [io_num-1:0] sync2;
   logic [io_num-1:0] sync3;

   // two-flop synchroniser then one delay stage
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         sync1 <= '0;
         sync2 <= '0;
         sync3 <= '0;
      end
      else
      begin
         sync1 <= gpio_i;
         sync2 <= sync1;
         sync3 <= sync2;
      end
   end

   assign level_o = sync3;

   // edge seen between stage two and stage three,
   // so a latch fed from these sets together with level_o
   assign rise_o = sync2 & ~sync3;
   assign fall_o = ~sync2 & sync3;

endmodule

// ==== verilog/gpio_irq.sv ====
module gpio_irq #(
   parameter int io_num = 32
) (
   input  logic                   PCLK,
   input  logic                   aresetn,
   input  gpio_cfg_pkg::pin_cfg_t cfg_i [io_num-1:0],
   input  logic [io_num-1:0]      level_i,
   input  logic [io_num-1:0]      rise_i,
   input  logic [io_num-1:0]      fall_i,
   input  logic                   irq_clr_i,
   input  logic [io_num-1:0]      irq_clr_mask_i,
   output logic [io_num-1:0]      int_o,
   output logic                   int_or_o,
   output logic [io_num-1:0]      intr_stat_o
);

   logic [io_num-1:0] int_en;
   logic [io_num-1:0] int_sel;
   logic [io_num-1:0] clr;
   logic [io_num-1:0] edge_pos;
   logic [io_num-1:0] edge_neg;
   logic [io_num-1:0] edge_both;

   // bits cleared by this cycle's write to the interrupt register
   assign clr = {io_num{irq_clr_i}} & irq_clr_mask_i;

   // ------------------------------------------------------------
   // sticky edge latches
   // ------------------------------------------------------------
   // held at zero while the pin interrupt is off;
   // a new edge wins over a clear in the same cycle
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         edge_pos  <= '0;
         edge_neg  <= '0;
         edge_both <= '0;
      end
      else
      begin
         edge_pos  <= int_en & (rise_i | (edge_pos & ~clr));
         edge_neg  <= int_en & (fall_i | (edge_neg & ~clr));
         edge_both <= int_en & (rise_i | fall_i | (edge_both & ~clr));
      end
   end

   // ------------------------------------------------------------
   // type select per pin
   // ------------------------------------------------------------
   always_comb
   begin
      for (int i = 0; i < io_num; i++)
      begin
         int_en[i] = cfg_i[i].int_en;
         case (cfg_i[i].int_type)
            gpio_cfg_pkg::INT_LEVEL_HIGH: int_sel[i] = level_i[i];
            gpio_cfg_pkg::INT_LEVEL_LOW:  int_sel[i] = ~level_i[i];
            gpio_cfg_pkg::INT_RISE:       int_sel[i] = edge_pos[i];
            gpio_cfg_pkg::INT_FALL:       int_sel[i] = edge_neg[i];
            gpio_cfg_pkg::INT_BOTH:       int_sel[i] = edge_both[i];
            // codes 5 to 7
            default:                      int_sel[i] = 1'b0;
         endcase
      end
   end

   assign int_o    = int_sel & int_en;
   assign int_or_o = |int_o;

   // status register, one cycle behind int_o
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         intr_stat_o <= '0;
      else
         intr_stat_o <= int_o & ~clr;
   end

endmodule

// ==== verilog/gpio_regmap_pkg.sv ====
package gpio_regmap_pkg;

   // ------------------------------------------------------------
   // apb data path
   // ------------------------------------------------------------
   localparam int DATA_W = 32;
   localparam int ADDR_W = 8;

   // ------------------------------------------------------------
   // register addresses
   // ------------------------------------------------------------
   // config words sit below this, one word per pin
   localparam logic [ADDR_W-1:0] CFG_LIMIT  = 8'h80;

   // interrupt status, a write clears masked bits
   localparam logic [ADDR_W-1:0] INTR_ADDR  = 8'h80;
   localparam logic [ADDR_W-1:0] GPIN_ADDR  = 8'h90;
   localparam logic [ADDR_W-1:0] GPOUT_ADDR = 8'hA0;

endpackage

// ==== verilog/gpio_top.sv ====
module gpio_top #(
   parameter int                io_num = 32,
   parameter logic [io_num-1:0] io_val = '0
) (
   input  logic                               PCLK,
   input  logic                               aresetn,
   input  logic                               PSEL,
   input  logic                               PENABLE,
   input  logic                               PWRITE,
   input  logic [gpio_regmap_pkg::ADDR_W-1:0] PADDR,
   input  logic [gpio_regmap_pkg::DATA_W-1:0] PWDATA,
   output logic [gpio_regmap_pkg::DATA_W-1:0] PRDATA,
   output logic                               PREADY,
   output logic                               PSLVERR,
   output logic [io_num-1:0]                  INT,
   output logic                               INT_OR,
   input  logic [io_num-1:0]                  GPIO_IN,
   output logic [io_num-1:0]                  GPIO_OUT,
   output logic [io_num-1:0]                  GPIO_OE
);

   logic [io_num-1:0]      level;
   logic [io_num-1:0]      rise;
   logic [io_num-1:0]      fall;
   gpio_cfg_pkg::pin_cfg_t cfg [io_num-1:0];
   logic                   irq_clr;
   logic [io_num-1:0]      irq_clr_mask;
   logic [io_num-1:0]      intr_stat;

   // no wait states, no error response
   assign PREADY  = 1'b1;
   assign PSLVERR = 1'b0;

   // ------------------------------------------------------------
   // input side
   // ------------------------------------------------------------
   gpio_in_sync #(
      .io_num (io_num)
   ) in_sync_inst (
      .PCLK    (PCLK),
      .aresetn (aresetn),
      .gpio_i  (GPIO_IN),
      .level_o (level),
      .rise_o  (rise),
      .fall_o  (fall)
   );

   // ------------------------------------------------------------
   // interrupt logic
   // ------------------------------------------------------------
   gpio_irq #(
      .io_num (io_num)
   ) irq_inst (
      .PCLK           (PCLK),
      .aresetn        (aresetn),
      .cfg_i          (cfg),
      .level_i        (level),
      .rise_i         (rise),
      .fall_i         (fall),
      .irq_clr_i      (irq_clr),
      .irq_clr_mask_i (irq_clr_mask),
      .int_o          (INT),
      .int_or_o       (INT_OR),
      .intr_stat_o    (intr_stat)
   );

   // ------------------------------------------------------------
   // register file and pin drive
   // ------------------------------------------------------------
   gpio_apb_regs #(
      .io_num (io_num),
      .io_val (io_val)
   ) apb_regs_inst (
      .PCLK           (PCLK),
      .aresetn        (aresetn),
      .psel_i         (PSEL),
      .penable_i      (PENABLE),
      .pwrite_i       (PWRITE),
      .paddr_i        (PADDR),
      .pwdata_i       (PWDATA),
      .prdata_o       (PRDATA),
      .level_i        (level),
      .intr_stat_i    (intr_stat),
      .cfg_o          (cfg),
      .irq_clr_o      (irq_clr),
      .irq_clr_mask_o (irq_clr_mask),
      .gpio_out_o     (GPIO_OUT),
      .gpio_oe_o      (GPIO_OE)
   );

endmodule
